// ==== Bender.yml ====
package:
  name: dab_pre_modulation

sources:
  # RTL in compile order
  - files:
      - hw/dab_pkg.sv
      - hw/dab_modulation_calc.sv
      - hw/dab_write_sequencer.sv
      - hw/dab_wb_write_master.sv
      - hw/dab_pre_modulation_top.sv

  # Verification sources
  - target: test
    files:
      - verif/dab_wb_chk.sv
      - verif/dab_tb.sv

// ==== dab_pre_modulation.f ====
hw/dab_pkg.sv
hw/dab_modulation_calc.sv
hw/dab_write_sequencer.sv
hw/dab_wb_write_master.sv
hw/dab_pre_modulation_top.sv
verif/dab_wb_chk.sv
verif/dab_tb.sv

// ==== hw/dab_modulation_calc.sv ====
// First pipeline stage: arbitrates the command strobes and registers a job
// with the eight PWM compare values, one cycle after the command
`timescale 1ns/1ps

module dab_modulation_calc (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 configure,
    input  logic                 start,
    input  logic                 stop,
    input  logic                 update,
    input  dab_pkg::modulation_t modulation_type,
    input  logic [15:0]          period,
    input  dab_pkg::mod_params_t params,
    input  logic                 modulator_status,
    input  logic                 seq_busy,
    output dab_pkg::job_t        job,
    output logic                 job_valid
);

    logic signed [15:0] half_period;
    logic signed [15:0] half_duty;
    logic signed [15:0] half_shift_1;
    logic signed [15:0] half_shift_2;
    logic signed [15:0] edge_low;
    logic signed [15:0] edge_high;
    logic               phase_shifted;
    logic               update_allowed;
    logic               accept;
    dab_pkg::command_t  kind;

    // Four compare values placed around one edge position of the bridge legs
    function automatic logic [3:0][15:0] edge_set(
        input logic signed [15:0] base,
        input logic signed [15:0] shift_1,
        input logic signed [15:0] shift_2,
        input logic               dual
    );
        logic [3:0][15:0] result;
        if (dual) begin
            result[0] = base - shift_2;
            result[1] = base + shift_2;
            result[2] = base + shift_1 - shift_2;
            result[3] = base + shift_1 + shift_2;
        end else begin
            result[0] = base;
            result[1] = base;
            result[2] = base + shift_1;
            result[3] = base + shift_1;
        end
        return result;
    endfunction

    // Halves are arithmetic shifts, everything wraps at 16 bits
    assign half_period = $signed(period) >>> 1;
    assign half_duty = $signed(params.duty) >>> 1;
    assign half_shift_1 = params.phase_shift_1 >>> 1;
    assign half_shift_2 = params.phase_shift_2 >>> 1;

    assign edge_low = half_period - half_duty;
    assign edge_high = half_period + half_duty;

    // Types 2 and 3 fall back to the symmetric pattern
    assign phase_shifted = (modulation_type == dab_pkg::mod_phase_shifted);

    // An update only makes sense while the modulator runs
    assign update_allowed = update && modulator_status;

    always_comb begin
        accept = !seq_busy && !job_valid && (stop || start || update_allowed || configure);
        if (stop) begin
            kind = dab_pkg::cmd_stop;
        end else if (start) begin
            kind = dab_pkg::cmd_start;
        end else if (update_allowed) begin
            kind = dab_pkg::cmd_update;
        end else begin
            kind = dab_pkg::cmd_configure;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            job_valid <= 1'b0;
        end else begin
            job_valid <= accept;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            job.kind <= kind;
            job.period <= period;
            job.deadtime <= params.deadtime;
            job.compare[3:0] <= edge_set(edge_low, half_shift_1, half_shift_2, phase_shifted);
            job.compare[7:4] <= edge_set(edge_high, half_shift_1, half_shift_2, phase_shifted);
        end
    end

endmodule

// ==== hw/dab_pkg.sv ====
// Register map, command encodings and bus structs shared by the DAB pre-modulation pipeline
// Every stage and the testbench refer to these by scoped names
package dab_pkg;

    localparam int N_PWM_CHANNELS = 4;
    localparam logic [31:0] PWM_BASE_ADDR = 32'h43C0_0000;

    // Offsets inside the PWM peripheral
    localparam logic [31:0] CTRL_OFFSET = 32'h0;
    localparam logic [31:0] PERIOD_OFFSET = 32'(32'h100 + (3 * N_PWM_CHANNELS + 1) * 4);
    localparam logic [31:0] DEADTIME_OFFSET = 32'(32'h100 + 2 * N_PWM_CHANNELS * 4);

    // Rising edge compare registers
    localparam logic [31:0] COMPARE_OFFSET_LOW [4] = '{
        32'(32'h100 + 4 * 0),
        32'(32'h100 + 4 * 1),
        32'(32'h100 + 4 * 2),
        32'(32'h100 + 4 * 3)
    };

    // Falling edge compare registers
    localparam logic [31:0] COMPARE_OFFSET_HIGH [4] = '{
        32'(32'h100 + 4 * (N_PWM_CHANNELS + 0)),
        32'(32'h100 + 4 * (N_PWM_CHANNELS + 1)),
        32'(32'h100 + 4 * (N_PWM_CHANNELS + 2)),
        32'(32'h100 + 4 * (N_PWM_CHANNELS + 3))
    };

    // Global configuration, written in index order
    localparam logic [31:0] GLOBAL_CFG_ADDR [4] = '{
        CTRL_OFFSET,
        32'(32'h100 + (3 * N_PWM_CHANNELS + 5) * 4),
        32'(32'h100 + (3 * N_PWM_CHANNELS + 4) * 4),
        32'(32'h100 + (3 * N_PWM_CHANNELS + 3) * 4)
    };
    localparam logic [31:0] GLOBAL_CFG_DATA [4] = '{32'h1100, 32'h1, 32'hF, 32'hFF};

    localparam logic [31:0] CTRL_ON_WORD = 32'h1128;
    localparam logic [31:0] CTRL_OFF_WORD = 32'hFF;

    // Write list lengths per command
    localparam int CONFIG_WRITES = 4;
    localparam int START_WRITES = N_PWM_CHANNELS + 10;
    localparam int UPDATE_WRITES = 9;
    localparam int STOP_WRITES = 1;
    localparam int WRITE_INDEX_W = $clog2(START_WRITES);

    typedef enum logic [1:0] {
        cmd_configure,
        cmd_start,
        cmd_update,
        cmd_stop
    } command_t;

    typedef enum logic [1:0] {
        mod_symmetric = 2'd0,
        mod_phase_shifted = 2'd1
    } modulation_t;

    typedef struct packed {
        logic [15:0]        duty;
        logic signed [15:0] phase_shift_1;
        logic signed [15:0] phase_shift_2;
        logic [15:0]        deadtime;
        logic [15:0]        spare;
    } mod_params_t;

    typedef struct packed {
        command_t         kind;
        logic [15:0]      period;
        logic [15:0]      deadtime;
        logic [7:0][15:0] compare;
    } job_t;

    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
    } write_cmd_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

endpackage

// ==== hw/dab_pre_modulation_top.sv ====
// DAB converter control front end: turns converter commands into PWM register
// writes on a Wishbone master port
`timescale 1ns/1ps

module dab_pre_modulation_top (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 configure,
    input  logic                 start,
    input  logic                 stop,
    input  logic                 update,
    input  dab_pkg::modulation_t modulation_type,
    input  logic [15:0]          period,
    input  dab_pkg::mod_params_t params,
    output dab_pkg::wb_req_t     wb,
    input  logic                 wb_ack,
    output logic                 modulator_status,
    output logic                 done
);

    dab_pkg::job_t       job;
    logic                job_valid;
    logic                seq_busy;
    dab_pkg::write_cmd_t wr_cmd;
    logic                wr_valid;
    logic                wr_ready;

    dab_modulation_calc i_modulation_calc (
        .clock            (clock),
        .reset            (reset),
        .configure        (configure),
        .start            (start),
        .stop             (stop),
        .update           (update),
        .modulation_type  (modulation_type),
        .period           (period),
        .params           (params),
        .modulator_status (modulator_status),
        .seq_busy         (seq_busy),
        .job              (job),
        .job_valid        (job_valid)
    );

    dab_write_sequencer i_write_sequencer (
        .clock            (clock),
        .reset            (reset),
        .job              (job),
        .job_valid        (job_valid),
        .seq_busy         (seq_busy),
        .wr_cmd           (wr_cmd),
        .wr_valid         (wr_valid),
        .wr_ready         (wr_ready),
        .modulator_status (modulator_status),
        .done             (done)
    );

    dab_wb_write_master i_wb_write_master (
        .clock    (clock),
        .reset    (reset),
        .wr_cmd   (wr_cmd),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wb       (wb),
        .wb_ack   (wb_ack)
    );

endmodule

// ==== hw/dab_wb_write_master.sv ====
// Third pipeline stage: Wishbone classic master issuing single writes
// Ready drops while a write is on the bus and returns after the ack
`timescale 1ns/1ps

module dab_wb_write_master (
    input  logic                clock,
    input  logic                reset,
    input  dab_pkg::write_cmd_t wr_cmd,
    input  logic                wr_valid,
    output logic                wr_ready,
    output dab_pkg::wb_req_t    wb,
    input  logic                wb_ack
);

    typedef enum logic {
        bus_idle,
        bus_write
    } bus_state_t;

    bus_state_t          state;
    dab_pkg::write_cmd_t cmd_q;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= bus_idle;
        end else begin
            case (state)
                bus_idle: begin
                    if (wr_valid) begin
                        state <= bus_write;
                    end
                end
                default: begin
                    if (wb_ack) begin
                        state <= bus_idle;
                    end
                end
            endcase
        end
    end

    // Address and data stay frozen for the whole bus cycle
    always_ff @(posedge clock) begin
        if (state == bus_idle && wr_valid) begin
            cmd_q <= wr_cmd;
        end
    end

    assign wr_ready = (state == bus_idle);

    always_comb begin
        wb.cyc = (state == bus_write);
        wb.stb = (state == bus_write);
        wb.we = (state == bus_write);
        wb.adr = cmd_q.adr;
        wb.dat = cmd_q.dat;
    end

endmodule

// ==== hw/dab_write_sequencer.sv ====
// Second pipeline stage: walks the register write list of a job and tracks whether
// the modulator is running, pulsing done once the last write has been acked
`timescale 1ns/1ps

module dab_write_sequencer (
    input  logic                clock,
    input  logic                reset,
    input  dab_pkg::job_t       job,
    input  logic                job_valid,
    output logic                seq_busy,
    output dab_pkg::write_cmd_t wr_cmd,
    output logic                wr_valid,
    input  logic                wr_ready,
    output logic                modulator_status,
    output logic                done
);

    typedef enum logic [1:0] {
        seq_idle,
        seq_issue,
        seq_drain
    } seq_state_t;

    seq_state_t                        state;
    dab_pkg::job_t                     job_q;
    logic [dab_pkg::WRITE_INDEX_W-1:0] index;
    logic                              transfer;
    logic                              last_write;

    function automatic int write_count(input dab_pkg::command_t kind);
        case (kind)
            dab_pkg::cmd_configure: return dab_pkg::CONFIG_WRITES;
            dab_pkg::cmd_start:     return dab_pkg::START_WRITES;
            dab_pkg::cmd_update:    return dab_pkg::UPDATE_WRITES;
            default:                return dab_pkg::STOP_WRITES;
        endcase
    endfunction

    // Step 0 is the period, steps 1 to 8 are the compare values
    function automatic dab_pkg::write_cmd_t timing_write(
        input dab_pkg::job_t j,
        input int            step
    );
        dab_pkg::write_cmd_t w;
        if (step == 0) begin
            w.adr = dab_pkg::PWM_BASE_ADDR + dab_pkg::PERIOD_OFFSET;
            w.dat = {16'h0, j.period};
        end else if (step <= 4) begin
            w.adr = dab_pkg::PWM_BASE_ADDR + dab_pkg::COMPARE_OFFSET_LOW[step - 1];
            w.dat = {16'h0, j.compare[step - 1]};
        end else begin
            w.adr = dab_pkg::PWM_BASE_ADDR + dab_pkg::COMPARE_OFFSET_HIGH[step - 5];
            w.dat = {16'h0, j.compare[step - 1]};
        end
        return w;
    endfunction

    function automatic dab_pkg::write_cmd_t build_write(
        input dab_pkg::job_t j,
        input int            idx
    );
        dab_pkg::write_cmd_t w;
        case (j.kind)
            dab_pkg::cmd_configure: begin
                w.adr = dab_pkg::PWM_BASE_ADDR + dab_pkg::GLOBAL_CFG_ADDR[idx];
                w.dat = dab_pkg::GLOBAL_CFG_DATA[idx];
            end
            dab_pkg::cmd_start: begin
                if (idx < dab_pkg::N_PWM_CHANNELS) begin
                    w.adr = dab_pkg::PWM_BASE_ADDR + dab_pkg::DEADTIME_OFFSET + 32'(4 * idx);
                    w.dat = {16'h0, j.deadtime};
                end else if (idx < dab_pkg::N_PWM_CHANNELS + 9) begin
                    w = timing_write(j, idx - dab_pkg::N_PWM_CHANNELS);
                end else begin
                    w.adr = dab_pkg::PWM_BASE_ADDR + dab_pkg::CTRL_OFFSET;
                    w.dat = dab_pkg::CTRL_ON_WORD;
                end
            end
            dab_pkg::cmd_update: begin
                w = timing_write(j, idx);
            end
            default: begin
                w.adr = dab_pkg::PWM_BASE_ADDR + dab_pkg::CTRL_OFFSET;
                w.dat = dab_pkg::CTRL_OFF_WORD;
            end
        endcase
        return w;
    endfunction

    assign seq_busy = (state != seq_idle);
    assign wr_valid = (state == seq_issue);
    assign wr_cmd = build_write(job_q, int'(index));
    assign transfer = wr_valid && wr_ready;
    assign last_write = (int'(index) == write_count(job_q.kind) - 1);

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= seq_idle;
            index <= '0;
            done <= 1'b0;
            modulator_status <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                seq_idle: begin
                    if (job_valid) begin
                        index <= '0;
                        state <= seq_issue;
                    end
                end
                seq_issue: begin
                    if (transfer) begin
                        if (last_write) begin
                            state <= seq_drain;
                        end else begin
                            index <= index + 1'b1;
                        end
                    end
                end
                seq_drain: begin
                    // Master back to ready means the last write was acked
                    if (wr_ready) begin
                        done <= 1'b1;
                        state <= seq_idle;
                        if (job_q.kind == dab_pkg::cmd_start) begin
                            modulator_status <= 1'b1;
                        end else if (job_q.kind == dab_pkg::cmd_stop) begin
                            modulator_status <= 1'b0;
                        end
                    end
                end
                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == seq_idle && job_valid) begin
            job_q <= job;
        end
    end

endmodule

// ==== verif/dab_tb.sv ====
// Testbench for the DAB pre-modulation front end. It applies a command table, plays the
// PWM peripheral as a Wishbone slave with random ack delays and checks every write
`timescale 1ns/1ps

module dab_tb;

    localparam int N_ROWS = 9;
    localparam int RESET_CYCLES = 10;
    localparam int CYCLES_PER_ROW = 200;
    localparam int IDLE_WINDOW = 20;

    // Strobe bits of a table row
    localparam logic [3:0] S_CONFIGURE = 4'b0001;
    localparam logic [3:0] S_UPDATE = 4'b0010;
    localparam logic [3:0] S_START = 4'b0100;
    localparam logic [3:0] S_STOP = 4'b1000;

    typedef struct packed {
        logic [3:0]           strobes;
        dab_pkg::modulation_t mod_type;
        logic [15:0]          period;
        dab_pkg::mod_params_t params;
        logic                 expect_on;
    } row_t;

    logic                 clock;
    logic                 reset;
    logic                 configure;
    logic                 start;
    logic                 stop;
    logic                 update;
    dab_pkg::modulation_t modulation_type;
    logic [15:0]          period;
    dab_pkg::mod_params_t params;
    dab_pkg::wb_req_t     wb;
    logic                 wb_ack;
    logic                 modulator_status;
    logic                 done;

    row_t                table_rows [N_ROWS];
    string               row_name [N_ROWS];
    string               current_test = "reset";
    logic                model_on;
    dab_pkg::write_cmd_t expected_writes [$];
    dab_pkg::write_cmd_t bus_log [$];
    logic                slave_busy;
    int                  ack_delay;

    dab_pre_modulation_top i_dab_pre_modulation_top (
        .clock            (clock),
        .reset            (reset),
        .configure        (configure),
        .start            (start),
        .stop             (stop),
        .update           (update),
        .modulation_type  (modulation_type),
        .period           (period),
        .params           (params),
        .wb               (wb),
        .wb_ack           (wb_ack),
        .modulator_status (modulator_status),
        .done             (done)
    );

    bind dab_wb_write_master dab_wb_chk i_wb_chk (
        .clock  (clock),
        .reset  (reset),
        .wb     (wb),
        .wb_ack (wb_ack)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic compare_value(input string test_name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: %s %s expected 0x%08h actual 0x%08h",
                     test_name, what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic row_t make_row(input logic [3:0] strobes, input int mod_type,
                                      input int per, input int duty, input int shift_1,
                                      input int shift_2, input int dead, input logic on);
        row_t r;
        r.strobes = strobes;
        r.mod_type = dab_pkg::modulation_t'(mod_type[1:0]);
        r.period = 16'(per);
        r.params.duty = 16'(duty);
        r.params.phase_shift_1 = 16'(shift_1);
        r.params.phase_shift_2 = 16'(shift_2);
        r.params.deadtime = 16'(dead);
        r.params.spare = '0;
        r.expect_on = on;
        return r;
    endfunction

    task automatic load_table();
        row_name[0] = "configure";
        table_rows[0] = make_row(S_CONFIGURE, 0, 0, 0, 0, 0, 0, 1'b0);
        row_name[1] = "update_while_off";
        table_rows[1] = make_row(S_UPDATE, 1, 1000, 200, 100, 50, 0, 1'b0);
        row_name[2] = "start_symmetric";
        table_rows[2] = make_row(S_START, 0, 1000, 300, 120, 50, 20, 1'b1);
        row_name[3] = "update_phase_shifted";
        table_rows[3] = make_row(S_UPDATE, 1, 1200, 401, 150, -37, 0, 1'b1);
        row_name[4] = "update_type_3";
        table_rows[4] = make_row(S_UPDATE, 3, 800, 250, -60, 10, 0, 1'b1);
        row_name[5] = "stop";
        table_rows[5] = make_row(S_STOP, 0, 0, 0, 0, 0, 0, 1'b0);
        // Duty larger than the period makes the low edges wrap below zero
        row_name[6] = "start_wrapping";
        table_rows[6] = make_row(S_START, 1, 100, 400, -30, -9, 7, 1'b1);
        row_name[7] = "stop_and_start";
        table_rows[7] = make_row(S_STOP | S_START, 0, 2000, 500, 40, 0, 15, 1'b0);
        row_name[8] = "update_after_stop";
        table_rows[8] = make_row(S_UPDATE, 0, 900, 100, 20, 0, 0, 1'b0);
    endtask

    task automatic push_write(input logic [31:0] offset, input logic [31:0] data);
        expected_writes.push_back({dab_pkg::PWM_BASE_ADDR + offset, data});
    endtask

    task automatic push_timing(input logic [15:0] per, input logic [7:0][15:0] cmp);
        push_write(dab_pkg::PERIOD_OFFSET, {16'h0, per});
        for (int i = 0; i < 4; i++) begin
            push_write(dab_pkg::COMPARE_OFFSET_LOW[i], {16'h0, cmp[i]});
        end
        for (int i = 0; i < 4; i++) begin
            push_write(dab_pkg::COMPARE_OFFSET_HIGH[i], {16'h0, cmp[i + 4]});
        end
    endtask

    // Builds the expected write list of one row from the modulator state before it
    task automatic build_expected(input row_t r, input logic on_before);
        logic [7:0][15:0]   cmp;
        logic signed [15:0] hp;
        logic signed [15:0] hd;
        logic signed [15:0] h1;
        logic signed [15:0] h2;
        logic signed [15:0] lo;
        logic signed [15:0] hi;
        expected_writes.delete();
        hp = $signed(r.period) >>> 1;
        hd = $signed(r.params.duty) >>> 1;
        h1 = r.params.phase_shift_1 >>> 1;
        h2 = r.params.phase_shift_2 >>> 1;
        lo = hp - hd;
        hi = hp + hd;
        if (r.mod_type == dab_pkg::mod_phase_shifted) begin
            cmp = {hi + h1 + h2, hi + h1 - h2, hi + h2, hi - h2,
                   lo + h1 + h2, lo + h1 - h2, lo + h2, lo - h2};
        end else begin
            cmp = {hi + h1, hi + h1, hi, hi, lo + h1, lo + h1, lo, lo};
        end
        if (r.strobes[3]) begin
            push_write(dab_pkg::CTRL_OFFSET, dab_pkg::CTRL_OFF_WORD);
        end else if (r.strobes[2]) begin
            for (int i = 0; i < dab_pkg::N_PWM_CHANNELS; i++) begin
                push_write(dab_pkg::DEADTIME_OFFSET + 32'(4 * i), {16'h0, r.params.deadtime});
            end
            push_timing(r.period, cmp);
            push_write(dab_pkg::CTRL_OFFSET, dab_pkg::CTRL_ON_WORD);
        end else if (r.strobes[1] && on_before) begin
            push_timing(r.period, cmp);
        end else if (r.strobes[0]) begin
            for (int i = 0; i < 4; i++) begin
                push_write(dab_pkg::GLOBAL_CFG_ADDR[i], dab_pkg::GLOBAL_CFG_DATA[i]);
            end
        end
    endtask

    task automatic run_row(input int idx);
        row_t r;
        r = table_rows[idx];
        current_test = row_name[idx];
        build_expected(r, model_on);
        bus_log.delete();
        @(negedge clock);
        {stop, start, update, configure} = r.strobes;
        modulation_type = r.mod_type;
        period = r.period;
        params = r.params;
        @(negedge clock);
        {stop, start, update, configure} = 4'b0000;
        if (expected_writes.size() > 0) begin
            while (!done) @(negedge clock);
        end else begin
            repeat (IDLE_WINDOW) begin
                @(negedge clock);
                compare_value(current_test, "done", 32'd0, 32'(done));
            end
        end
        compare_value(current_test, "write count", 32'(expected_writes.size()),
                      32'(bus_log.size()));
        foreach (expected_writes[i]) begin
            compare_value(current_test, $sformatf("adr of write %0d", i),
                          expected_writes[i].adr, bus_log[i].adr);
            compare_value(current_test, $sformatf("dat of write %0d", i),
                          expected_writes[i].dat, bus_log[i].dat);
        end
        compare_value(current_test, "modulator_status", 32'(r.expect_on),
                      32'(modulator_status));
        model_on = r.expect_on;
    endtask

    // The PWM peripheral acks each write after 0 to 3 wait cycles and logs it
    initial begin
        wb_ack = 1'b0;
        slave_busy = 1'b0;
        ack_delay = 0;
        void'($urandom(84));
        forever begin
            @(negedge clock);
            if (reset && wb.cyc && wb.stb && !wb_ack) begin
                if (!slave_busy) begin
                    slave_busy = 1'b1;
                    ack_delay = int'($urandom % 4);
                end
                if (ack_delay == 0) begin
                    compare_value(current_test, "we", 32'd1, 32'(wb.we));
                    bus_log.push_back({wb.adr, wb.dat});
                    wb_ack = 1'b1;
                    slave_busy = 1'b0;
                end else begin
                    ack_delay--;
                end
            end else begin
                wb_ack = 1'b0;
            end
        end
    end

    initial begin
        repeat (RESET_CYCLES + N_ROWS * CYCLES_PER_ROW) @(posedge clock);
        $display("timeout: the command table did not complete in %0d cycles",
                 RESET_CYCLES + N_ROWS * CYCLES_PER_ROW);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    // A bus protocol assertion failure ends the run at once
    initial begin
        wait (i_dab_pre_modulation_top.i_wb_write_master.i_wb_chk.violations != 0);
        $display("bus protocol assertion failed during %s", current_test);
        $display("Simulation finished: FAIL");
        $fatal(1, "bus protocol violated");
    end

    initial begin
        reset = 1'b0;
        configure = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        update = 1'b0;
        modulation_type = dab_pkg::mod_symmetric;
        period = '0;
        params = '0;
        model_on = 1'b0;
        load_table();
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b1;
        for (int i = 0; i < N_ROWS; i++) begin
            run_row(i);
        end
        repeat (4) @(negedge clock);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== verif/dab_wb_chk.sv ====
// Wishbone classic protocol assertions, bound onto the write master by the testbench
`timescale 1ns/1ps

module dab_wb_chk (
    input logic             clock,
    input logic             reset,
    input dab_pkg::wb_req_t wb,
    input logic             wb_ack
);

    int violations = 0;

    // A strobe is only meaningful inside a bus cycle
    stb_inside_cyc: assert property (@(posedge clock) disable iff (!reset) wb.stb |-> wb.cyc)
        else begin
            violations++;
            $error("stb is high while cyc is low");
        end

    // Until the slave acks, the request is held with the same address and data
    request_stable: assert property (@(posedge clock) disable iff (!reset)
        (wb.stb && !wb_ack) |=> (wb.stb && $stable(wb.adr) && $stable(wb.dat)))
        else begin
            violations++;
            $error("request changed or dropped before ack");
        end

    cyc_low_after_reset: assert property (@(posedge clock) !reset |=> !wb.cyc)
        else begin
            violations++;
            $error("cyc is high right after reset");
        end

endmodule
